//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert
TOP       = tb_mips
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/mips_chk.sv
/*
 * pipeline property checks, bound into the core
 */
`timescale 1ns/1ps

module mips_chk (
    input logic                SYS_clk,
    input logic                SYS_reset,
    input mips_pkg::word_t     pc,
    input logic                stall,
    input logic                wb_en,
    input mips_pkg::reg_addr_t wb_addr
);

    pc_hold_on_stall: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        stall |=> $stable(pc))
        else $error("pc changed while decode was stalled");

    no_r0_writeback: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(wb_en && (wb_addr == '0)))
        else $error("write-back enabled for register zero");

    no_stall_in_reset: assert property (@(posedge SYS_clk)
        SYS_reset |-> !stall)
        else $error("stall raised during reset");

endmodule

bind mips_core mips_chk u_chk (
    .SYS_clk   (SYS_clk),
    .SYS_reset (SYS_reset),
    .pc        (pc),
    .stall     (stall),
    .wb_en     (wb_en),
    .wb_addr   (wb_addr)
);

//--- sim/tb_mips.sv
/*
 * testbench for the five-stage MIPS-like pipeline
 * builds LFSR programs, runs them on the core and on an
 * instruction-set model, then compares every register
 */
`timescale 1ns/1ps

module tb_mips;

    localparam int IMEM_DEPTH   = 64;
    localparam int DMEM_DEPTH   = 16;
    localparam int IM_AW        = $clog2(IMEM_DEPTH);
    localparam int DM_AW        = $clog2(DMEM_DEPTH);
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 2;
    localparam int NUM_PROGS    = 5;
    localparam int NUM_RAND     = 40;
    localparam int HALT_IDX     = IMEM_DEPTH - 1;
    localparam int RUN_WAIT     = 4 * IMEM_DEPTH + 20;
    localparam int PROG_CYCLES  = IMEM_DEPTH + RESET_CYCLES + 2 + RUN_WAIT + 2 * 32;
    localparam int WATCHDOG_NS  = 2 * NUM_PROGS * PROG_CYCLES * CLK_PERIOD;
    localparam logic [15:0] LFSR_SEED = 16'd80;

    logic                SYS_clk;
    logic                SYS_reset;
    logic                load_en;
    logic [IM_AW-1:0]    load_addr;
    mips_pkg::word_t     load_data;
    mips_pkg::reg_addr_t dbg_addr;
    mips_pkg::word_t     dbg_data;

    mips_pkg::word_t prog [IMEM_DEPTH];
    mips_pkg::word_t exp_regs [32];
    mips_pkg::word_t exp_mem [DMEM_DEPTH];
    logic [15:0]     lfsr;
    event            run_done;
    event            check_done;

    mips_core #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_dut (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data)
    );

    initial
    begin
        SYS_clk = 1'b0;
        forever #(CLK_PERIOD / 2) SYS_clk = ~SYS_clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = (v << 1) | {31'd0, lfsr[0]};
        end
        return v;
    endfunction

    function automatic mips_pkg::word_t enc_r(input logic [5:0] funct,
                                              input mips_pkg::reg_addr_t rd,
                                              input mips_pkg::reg_addr_t rs,
                                              input mips_pkg::reg_addr_t rt);
        return {6'd0, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic mips_pkg::word_t enc_i(input logic [5:0] op,
                                              input mips_pkg::reg_addr_t rs,
                                              input mips_pkg::reg_addr_t rt,
                                              input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic build_program();
        int unsigned         kind;
        mips_pkg::reg_addr_t rd;
        mips_pkg::reg_addr_t rs;
        mips_pkg::reg_addr_t rt;
        for (int i = 0; i < DMEM_DEPTH; i++)
            prog[i] = enc_i(mips_pkg::OP_SW, 5'd0, 5'd0, 16'(4 * i));     // clear data memory
        for (int i = DMEM_DEPTH; i < DMEM_DEPTH + NUM_RAND; i++)
        begin
            kind = rand_bits(3);
            rd   = 5'(rand_bits(3));   // r0..r7 keeps dependencies dense
            rs   = 5'(rand_bits(3));
            rt   = 5'(rand_bits(3));
            case (kind)
                0: prog[i] = enc_r(mips_pkg::FN_ADD, rd, rs, rt);
                1: prog[i] = enc_r(mips_pkg::FN_SUB, rd, rs, rt);
                2: prog[i] = enc_r(mips_pkg::FN_AND, rd, rs, rt);
                3: prog[i] = enc_r(mips_pkg::FN_OR, rd, rs, rt);
                4: prog[i] = enc_r(mips_pkg::FN_SLT, rd, rs, rt);
                5: prog[i] = enc_i(mips_pkg::OP_ADDI, rs, rd, 16'(rand_bits(16)));
                6:
                begin
                    if (rand_bits(1) == 1)
                        prog[i] = enc_i(mips_pkg::OP_LW, rs, rd, 16'(4 * rand_bits(4)));
                    else
                        prog[i] = enc_i(mips_pkg::OP_SW, rs, rt, 16'(4 * rand_bits(4)));
                end
                default:
                begin
                    if (rand_bits(1) == 1)
                        prog[i] = enc_i(mips_pkg::OP_BEQ, rs, rt, 16'(rand_bits(2)));
                    else
                        prog[i] = enc_i(mips_pkg::OP_BNE, rs, rt, 16'(rand_bits(2)));
                end
            endcase
        end
        for (int i = DMEM_DEPTH + NUM_RAND; i < HALT_IDX; i++)
            prog[i] = '0;
        prog[HALT_IDX] = enc_i(mips_pkg::OP_BEQ, 5'd0, 5'd0, 16'hFFFF);   // branch to self
    endtask

    // instruction-set model of the program, stops at the halt loop
    function automatic void run_model();
        mips_pkg::word_t     ins;
        mips_pkg::word_t     a;
        mips_pkg::word_t     b;
        mips_pkg::word_t     imm;
        mips_pkg::word_t     addr;
        mips_pkg::reg_addr_t dest;
        mips_pkg::word_t     res;
        logic                wr;
        int unsigned         pc_idx;
        int unsigned         steps;
        for (int r = 0; r < 32; r++)
            exp_regs[r] = '0;
        for (int m = 0; m < DMEM_DEPTH; m++)
            exp_mem[m] = '0;
        pc_idx = 0;
        steps  = 0;
        while ((pc_idx != HALT_IDX) && (steps < IMEM_DEPTH))
        begin
            ins    = prog[pc_idx];
            a      = exp_regs[ins[25:21]];
            b      = exp_regs[ins[20:16]];
            imm    = {{16{ins[15]}}, ins[15:0]};
            addr   = a + imm;
            dest   = ins[20:16];
            res    = '0;
            wr     = 1'b0;
            pc_idx = pc_idx + 1;
            case (ins[31:26])
                mips_pkg::OP_RTYPE:
                begin
                    dest = ins[15:11];
                    wr   = 1'b1;
                    case (ins[5:0])
                        mips_pkg::FN_ADD: res = a + b;
                        mips_pkg::FN_SUB: res = a - b;
                        mips_pkg::FN_AND: res = a & b;
                        mips_pkg::FN_OR:  res = a | b;
                        mips_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:          wr = 1'b0;     // nop
                    endcase
                end
                mips_pkg::OP_ADDI:
                begin
                    res = addr;
                    wr  = 1'b1;
                end
                mips_pkg::OP_LW:
                begin
                    res = exp_mem[addr[DM_AW+1:2]];
                    wr  = 1'b1;
                end
                mips_pkg::OP_SW:  exp_mem[addr[DM_AW+1:2]] = b;
                mips_pkg::OP_BEQ:
                begin
                    if (a == b)
                        pc_idx = pc_idx + imm;
                end
                mips_pkg::OP_BNE:
                begin
                    if (a != b)
                        pc_idx = pc_idx + imm;
                end
                default: wr = 1'b0;
            endcase
            if (wr && (dest != '0))
                exp_regs[dest] = res;
            steps = steps + 1;
        end
    endfunction

    task automatic after_edge();
        @(posedge SYS_clk);
        #DRIVE_DLY;
    endtask

    // reset stays high over the load and two more cycles
    task automatic load_program();
        after_edge();
        SYS_reset = 1'b1;
        for (int i = 0; i < IMEM_DEPTH; i++)
        begin
            load_en   = 1'b1;
            load_addr = IM_AW'(i);
            load_data = prog[i];
            after_edge();
        end
        load_en = 1'b0;
        repeat (RESET_CYCLES) after_edge();
        SYS_reset = 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] dbg_data %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "register value mismatch");
        end
    endtask

    initial
    begin
        dbg_addr = '0;
        forever
        begin
            @(run_done);
            for (int r = 0; r < 32; r++)
            begin
                after_edge();
                dbg_addr = 5'(r);
                @(negedge SYS_clk);   // debug read settled
                check_value($sformatf("r%0d", r), dbg_data, exp_regs[r]);
            end
            -> check_done;
        end
    end

    initial
    begin
        SYS_reset = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        lfsr      = LFSR_SEED;
        for (int p = 0; p < NUM_PROGS; p++)
        begin
            build_program();
            run_model();
            load_program();
            repeat (RUN_WAIT) @(posedge SYS_clk);   // no done flag, wait the bound
            -> run_done;
            @(check_done);
        end
        $display("TEST PASS");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("TEST FAIL");
        $fatal(1, "timeout, the run did not finish in the expected time");
    end

endmodule

//--- src/decode_unit.sv
/*
 * decode stage
 * IF/ID register, control decode, operand forwarding
 * and early beq/bne resolution
 */
`timescale 1ns/1ps

module decode_unit (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::word_t     pc,
    input  mips_pkg::word_t     instr,
    input  logic                stall,
    input  logic                fwd_a,
    input  logic                fwd_b,
    fwd_if.receiver             fwd,
    input  logic                wb_en,
    input  mips_pkg::reg_addr_t wb_addr,
    input  mips_pkg::word_t     wb_data,
    input  mips_pkg::reg_addr_t dbg_addr,
    output mips_pkg::word_t     dbg_data,
    output mips_pkg::reg_addr_t rs,
    output mips_pkg::reg_addr_t rt,
    output logic                uses_rt,
    output logic                branch_taken,
    output mips_pkg::word_t     branch_target,
    id_ex_if.driver             id_ex
);
    mips_pkg::word_t   instr_q;
    mips_pkg::word_t   pc_q;
    mips_pkg::word_t   imm;
    mips_pkg::word_t   rd_a;
    mips_pkg::word_t   rd_b;
    mips_pkg::word_t   op_a;
    mips_pkg::word_t   op_b;
    mips_pkg::opcode_e opcode;
    mips_pkg::ctrl_t   ctrl;
    logic              is_rtype;
    logic              is_branch;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            instr_q <= '0;
            pc_q    <= '0;
        end
        else if (!stall)
        begin
            instr_q <= branch_taken ? '0 : instr;   // squash fall-through, no delay slot
            pc_q    <= pc;
        end
    end

    assign opcode    = mips_pkg::opcode_e'(instr_q[31:26]);
    assign rs        = instr_q[25:21];
    assign rt        = instr_q[20:16];
    assign imm       = {{16{instr_q[15]}}, instr_q[15:0]};
    assign is_rtype  = (opcode == mips_pkg::OP_RTYPE);
    assign is_branch = (opcode == mips_pkg::OP_BEQ) || (opcode == mips_pkg::OP_BNE);
    assign uses_rt   = is_rtype || is_branch || (opcode == mips_pkg::OP_SW);

    always_comb
    begin
        ctrl = '0;
        case (opcode)
            mips_pkg::OP_RTYPE:
            begin
                ctrl.reg_write = 1'b1;
                case (mips_pkg::funct_e'(instr_q[5:0]))
                    mips_pkg::FN_ADD: ctrl.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB: ctrl.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: ctrl.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:  ctrl.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT: ctrl.alu_op = mips_pkg::ALU_SLT;
                    default:          ctrl.reg_write = 1'b0;    // nop lands here
                endcase
            end
            mips_pkg::OP_ADDI:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            mips_pkg::OP_LW:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            mips_pkg::OP_SW:
            begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            default: ctrl = '0;     // branches finish here in decode
        endcase
    end

    reg_file u_reg_file (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .ra        (rs),
        .rb        (rt),
        .dbg_addr  (dbg_addr),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .rd_a      (rd_a),
        .rd_b      (rd_b),
        .dbg_data  (dbg_data)
    );

    assign op_a = fwd_a ? fwd.mem_result : rd_a;
    assign op_b = fwd_b ? fwd.mem_result : rd_b;

    // beq taken on equal, bne on not equal
    assign branch_taken  = is_branch && !stall &&
                           ((opcode == mips_pkg::OP_BEQ) == (op_a == op_b));
    assign branch_target = pc_q + 32'd4 + {imm[29:0], 2'b00};

    assign id_ex.operand_a = op_a;
    assign id_ex.operand_b = op_b;
    assign id_ex.imm       = imm;
    assign id_ex.dest      = is_rtype ? instr_q[15:11] : rt;
    assign id_ex.ctrl      = ctrl;
    assign id_ex.valid     = !stall && (instr_q != '0);    // bubble while stalled

endmodule

//--- src/execute_unit.sv
/*
 * execute stage
 * ID/EX register and the ALU
 */
`timescale 1ns/1ps

module execute_unit (
    input  logic      SYS_clk,
    input  logic      SYS_reset,
    id_ex_if.receiver id_ex,
    ex_mem_if.driver  ex_mem
);
    mips_pkg::word_t     a_q;
    mips_pkg::word_t     b_q;
    mips_pkg::word_t     imm_q;
    mips_pkg::reg_addr_t dest_q;
    mips_pkg::ctrl_t     ctrl_q;
    logic                valid_q;
    mips_pkg::word_t     alu_b;
    mips_pkg::word_t     result;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            ctrl_q  <= '0;
            valid_q <= 1'b0;
        end
        else
        begin
            ctrl_q  <= id_ex.ctrl;
            valid_q <= id_ex.valid;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        a_q    <= id_ex.operand_a;
        b_q    <= id_ex.operand_b;
        imm_q  <= id_ex.imm;
        dest_q <= id_ex.dest;
    end

    assign alu_b = ctrl_q.alu_src_imm ? imm_q : b_q;

    always_comb
    begin
        case (ctrl_q.alu_op)
            mips_pkg::ALU_SUB: result = a_q - alu_b;
            mips_pkg::ALU_AND: result = a_q & alu_b;
            mips_pkg::ALU_OR:  result = a_q | alu_b;
            mips_pkg::ALU_SLT: result = {{(mips_pkg::DATA_W-1){1'b0}},
                                         $signed(a_q) < $signed(alu_b)};
            default:           result = a_q + alu_b;   // add, wraps, also addresses
        endcase
    end

    assign ex_mem.alu_result = result;
    assign ex_mem.store_data = b_q;
    assign ex_mem.dest       = dest_q;
    assign ex_mem.ctrl       = valid_q ? ctrl_q : '0;   // bubble has no effect

endmodule

//--- src/fetch_unit.sv
/*
 * fetch stage
 * program counter with hold and branch redirect, and the
 * instruction memory with a load port for program placement
 */
`timescale 1ns/1ps

module fetch_unit #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          SYS_clk,
    input  logic                          SYS_reset,
    input  logic                          load_en,
    input  logic [$clog2(IMEM_DEPTH)-1:0] load_addr,
    input  mips_pkg::word_t               load_data,
    input  logic                          stall,
    input  logic                          branch_taken,
    input  mips_pkg::word_t               branch_target,
    output mips_pkg::word_t               pc,
    output mips_pkg::word_t               instr
);
    localparam int IM_AW = $clog2(IMEM_DEPTH);

    mips_pkg::word_t imem [IMEM_DEPTH];

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            pc <= '0;
        else if (stall)
            pc <= pc;                   // decode is waiting
        else if (branch_taken)
            pc <= branch_target;
        else
            pc <= pc + 32'd4;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (load_en)
            imem[load_addr] <= load_data;
    end

    assign instr = imem[pc[IM_AW+1:2]];  // word index

endmodule

//--- src/hazard_unit.sv
/*
 * hazard detection
 * compares decode sources with the execute and memory destinations,
 * raises stall or selects the memory-stage forward
 */
`timescale 1ns/1ps

module hazard_unit (
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    input  logic                uses_rt,
    ex_mem_if.monitor           ex,
    fwd_if.receiver             fwd,
    output logic                stall,
    output logic                fwd_a,
    output logic                fwd_b
);
    logic a_ex;
    logic b_ex;
    logic a_mem;
    logic b_mem;

    // producer still in execute, no value yet
    assign a_ex = (rs != '0) && (rs == ex.dest) && ex.ctrl.reg_write;
    assign b_ex = uses_rt && (rt != '0) && (rt == ex.dest) && ex.ctrl.reg_write;

    // producer in memory stage
    assign a_mem = (rs != '0) && (rs == fwd.mem_dest) && fwd.mem_reg_write;
    assign b_mem = uses_rt && (rt != '0) && (rt == fwd.mem_dest) && fwd.mem_reg_write;

    // load data only appears in write-back, so wait one more cycle
    assign stall = a_ex || b_ex || ((a_mem || b_mem) && fwd.mem_is_load);

    assign fwd_a = a_mem && !fwd.mem_is_load;
    assign fwd_b = b_mem && !fwd.mem_is_load;

endmodule

//--- src/memory_unit.sv
/*
 * memory and write-back stages
 * EX/MEM register, data memory, MEM/WB register
 * and the write-back port to the register file
 */
`timescale 1ns/1ps

module memory_unit #(
    parameter int DMEM_DEPTH = 16
) (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    ex_mem_if.receiver          ex_mem,
    fwd_if.driver               fwd,
    output logic                wb_en,
    output mips_pkg::reg_addr_t wb_addr,
    output mips_pkg::word_t     wb_data
);
    localparam int DM_AW = $clog2(DMEM_DEPTH);

    mips_pkg::word_t     dmem [DMEM_DEPTH];
    mips_pkg::ctrl_t     ctrl_q;
    mips_pkg::reg_addr_t dest_q;
    mips_pkg::word_t     alu_q;
    mips_pkg::word_t     store_q;
    mips_pkg::word_t     load_data;
    logic [DM_AW-1:0]    dm_idx;
    logic                wb_write_q;
    mips_pkg::reg_addr_t wb_dest_q;
    mips_pkg::word_t     wb_data_q;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            ctrl_q     <= '0;
            dest_q     <= '0;
            wb_write_q <= 1'b0;
            wb_dest_q  <= '0;
        end
        else
        begin
            ctrl_q     <= ex_mem.ctrl;
            dest_q     <= ex_mem.dest;
            wb_write_q <= ctrl_q.reg_write && (dest_q != '0);   // r0 never written
            wb_dest_q  <= dest_q;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        alu_q     <= ex_mem.alu_result;
        store_q   <= ex_mem.store_data;
        wb_data_q <= ctrl_q.mem_read ? load_data : alu_q;
    end

    assign dm_idx = alu_q[DM_AW+1:2];   // word index, wraps at depth

    always_ff @(posedge SYS_clk)
    begin
        if (ctrl_q.mem_write)
            dmem[dm_idx] <= store_q;
    end

    assign load_data = dmem[dm_idx];

    assign fwd.mem_dest      = dest_q;
    assign fwd.mem_reg_write = ctrl_q.reg_write;
    assign fwd.mem_is_load   = ctrl_q.mem_read;
    assign fwd.mem_result    = alu_q;

    assign wb_en   = wb_write_q;
    assign wb_addr = wb_dest_q;
    assign wb_data = wb_data_q;

endmodule

//--- src/mips_core.sv
/*
 * five-stage MIPS-like pipeline, top level
 * fetch, decode, execute, memory and write-back with
 * decode-stage hazard stall and forwarding
 */
`timescale 1ns/1ps

module mips_core #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 16
) (
    input  logic                          SYS_clk,
    input  logic                          SYS_reset,
    input  logic                          load_en,
    input  logic [$clog2(IMEM_DEPTH)-1:0] load_addr,
    input  mips_pkg::word_t               load_data,
    input  mips_pkg::reg_addr_t           dbg_addr,
    output mips_pkg::word_t               dbg_data
);
    mips_pkg::word_t     pc;
    mips_pkg::word_t     instr;
    mips_pkg::word_t     branch_target;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t wb_addr;
    mips_pkg::word_t     wb_data;
    logic                stall;
    logic                fwd_a;
    logic                fwd_b;
    logic                uses_rt;
    logic                branch_taken;
    logic                wb_en;

    id_ex_if  u_id_ex ();
    ex_mem_if u_ex_mem ();
    fwd_if    u_fwd ();

    fetch_unit #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_fetch (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .load_en       (load_en),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (pc),
        .instr         (instr)
    );

    decode_unit u_decode (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .pc            (pc),
        .instr         (instr),
        .stall         (stall),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .fwd           (u_fwd.receiver),
        .wb_en         (wb_en),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .dbg_addr      (dbg_addr),
        .dbg_data      (dbg_data),
        .rs            (rs),
        .rt            (rt),
        .uses_rt       (uses_rt),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .id_ex         (u_id_ex.driver)
    );

    hazard_unit u_hazard (
        .rs      (rs),
        .rt      (rt),
        .uses_rt (uses_rt),
        .ex      (u_ex_mem.monitor),
        .fwd     (u_fwd.receiver),
        .stall   (stall),
        .fwd_a   (fwd_a),
        .fwd_b   (fwd_b)
    );

    execute_unit u_execute (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .id_ex     (u_id_ex.receiver),
        .ex_mem    (u_ex_mem.driver)
    );

    memory_unit #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_memory (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .ex_mem    (u_ex_mem.receiver),
        .fwd       (u_fwd.driver),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

endmodule

//--- src/mips_pkg.sv
/*
 * mips pipeline shared definitions
 * word and register index types, opcode and funct encodings,
 * ALU operations and the control bundle carried down the pipe
 */
package mips_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDI  = 6'd8,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'd32,
        FN_SUB = 6'd34,
        FN_AND = 6'd36,
        FN_OR  = 6'd37,
        FN_SLT = 6'd42
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;   // second ALU operand from imm
        alu_op_e alu_op;
    } ctrl_t;

endpackage

//--- src/pipe_if.sv
/*
 * pipeline stage bundles
 * decode to execute, execute to memory, and the memory-stage
 * forwarding view used by decode and the hazard logic
 */
`timescale 1ns/1ps

interface id_ex_if;
    mips_pkg::word_t     operand_a;
    mips_pkg::word_t     operand_b;
    mips_pkg::word_t     imm;
    mips_pkg::reg_addr_t dest;
    mips_pkg::ctrl_t     ctrl;
    logic                valid;     // low for a bubble

    modport driver   (output operand_a, operand_b, imm, dest, ctrl, valid);
    modport receiver (input  operand_a, operand_b, imm, dest, ctrl, valid);
endinterface

interface ex_mem_if;
    mips_pkg::word_t     alu_result;
    mips_pkg::word_t     store_data;
    mips_pkg::reg_addr_t dest;
    mips_pkg::ctrl_t     ctrl;

    modport driver   (output alu_result, store_data, dest, ctrl);
    modport receiver (input  alu_result, store_data, dest, ctrl);
    modport monitor  (input  dest, ctrl);
endinterface

interface fwd_if;
    mips_pkg::reg_addr_t mem_dest;
    logic                mem_reg_write;
    logic                mem_is_load;
    mips_pkg::word_t     mem_result;

    modport driver   (output mem_dest, mem_reg_write, mem_is_load, mem_result);
    modport receiver (input  mem_dest, mem_reg_write, mem_is_load, mem_result);
endinterface

//--- src/reg_file.sv
/*
 * register file
 * 32 words, two read ports and a debug port, all with write-through
 */
`timescale 1ns/1ps

module reg_file (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::reg_addr_t ra,
    input  mips_pkg::reg_addr_t rb,
    input  mips_pkg::reg_addr_t dbg_addr,
    input  logic                wb_en,
    input  mips_pkg::reg_addr_t wb_addr,
    input  mips_pkg::word_t     wb_data,
    output mips_pkg::word_t     rd_a,
    output mips_pkg::word_t     rd_b,
    output mips_pkg::word_t     dbg_data
);
    mips_pkg::word_t regs [32];
    logic            wr_ok;

    function automatic mips_pkg::word_t read_port(input mips_pkg::reg_addr_t addr);
        if (wr_ok && (addr == wb_addr))
            return wb_data;     // same-cycle write wins
        return regs[addr];
    endfunction

    assign wr_ok = wb_en && (wb_addr != '0);   // r0 stays zero

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            regs <= '{default: '0};
        else if (wr_ok)
            regs[wb_addr] <= wb_data;
    end

    always_comb
    begin
        rd_a     = read_port(ra);
        rd_b     = read_port(rb);
        dbg_data = read_port(dbg_addr);
    end

endmodule

//--- verilog.f
src/mips_pkg.sv
src/pipe_if.sv
src/reg_file.sv
src/fetch_unit.sv
src/decode_unit.sv
src/hazard_unit.sv
src/execute_unit.sv
src/memory_unit.sv
src/mips_core.sv
sim/mips_chk.sv
sim/tb_mips.sv
